// ==== bcMiner.f ====
minerPkg.sv
hashCore.sv
latticeBlock.sv
blockStore.sv
nonceDecoder.sv
bcMiner.sv
bcMinerAssertions.sv
bcMinerTb.sv

// ==== bcMiner.sv ====
`timescale 1ns/1ps

module bcMiner import minerPkg::*; (
	input  logic        clk,
	input  logic        arstN_i,
	input  logic        wrReq_i,
	input  logic [2:0]  wrAddr_i,
	input  logic [31:0] wrData_i,
	output logic        wrAck_o,
	output logic        resReq_o,
	input  logic        resAck_i,
	output logic        resSuccess_o,
	output logic [31:0] resNonce_o
);

	// Entry i feeds lattice block i
	logic [NUM_CORES:0]            bcValid;
	logic [NUM_CORES:0]            bcNewBlock;
	logic [HEADER_WORDS-1:0][31:0] bcHeader [NUM_CORES+1];
	logic [31:0]                   bcTarget [NUM_CORES+1];

	logic [NUM_CORES-1:0]               hit;
	logic [NUM_CORES-1:0][CNT_BITS-1:0] hitCnt;
	logic [NUM_CORES-1:0]               exhausted;
	logic                               searchDone;

	blockStore blockStoreInst (
		.clk,
		.arstN_i,
		.wrReq_i,
		.wrAddr_i,
		.wrData_i,
		.wrAck_o,
		.searchDone_i (searchDone),
		.bcValid_o    (bcValid[0]),
		.bcNewBlock_o (bcNewBlock[0]),
		.bcHeader_o   (bcHeader[0]),
		.bcTarget_o   (bcTarget[0])
	);

	for (genvar i = 0; i < NUM_CORES; i++) begin : gLattice
		latticeBlock #(.INDEX(i)) latticeInst (
			.clk,
			.arstN_i,
			.bcValid_i    (bcValid[i]),
			.bcNewBlock_i (bcNewBlock[i]),
			.bcHeader_i   (bcHeader[i]),
			.bcTarget_i   (bcTarget[i]),
			.bcValid_o    (bcValid[i+1]),
			.bcNewBlock_o (bcNewBlock[i+1]),
			.bcHeader_o   (bcHeader[i+1]),
			.bcTarget_o   (bcTarget[i+1]),
			.hit_o        (hit[i]),
			.hitCnt_o     (hitCnt[i]),
			.exhausted_o  (exhausted[i])
		);
	end

	nonceDecoder nonceDecoderInst (
		.clk,
		.arstN_i,
		.hit_i        (hit),
		.hitCnt_i     (hitCnt),
		.exhausted_i  (exhausted),
		.searchDone_o (searchDone),
		.resReq_o,
		.resAck_i,
		.resSuccess_o,
		.resNonce_o
	);

endmodule

// ==== bcMinerAssertions.sv ====
`timescale 1ns/1ps

module bcMinerAssertions (
	input logic        clk,
	input logic        arstN_i,
	input logic        wrReq_i,
	input logic        wrAck_i,
	input logic        resReq_i,
	input logic        resAck_i,
	input logic        resSuccess_i,
	input logic [31:0] resNonce_i
);

	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN_i)
		$rose(wrAck_i) |-> $past(wrReq_i))
		else $error("wrAck_o rose with no write request pending");

	// Request holds until the host answers
	reqHeldToAck: assert property (@(posedge clk) disable iff (!arstN_i)
		resReq_i && !resAck_i |=> resReq_i)
		else $error("resReq_o dropped before resAck_i");

	resultStable: assert property (@(posedge clk) disable iff (!arstN_i)
		resReq_i && $past(resReq_i) |-> $stable(resSuccess_i) && $stable(resNonce_i))
		else $error("Result data changed while resReq_o was high");

endmodule

bind bcMiner bcMinerAssertions assertInst (
	.clk          (clk),
	.arstN_i      (arstN_i),
	.wrReq_i      (wrReq_i),
	.wrAck_i      (wrAck_o),
	.resReq_i     (resReq_o),
	.resAck_i     (resAck_i),
	.resSuccess_i (resSuccess_o),
	.resNonce_i   (resNonce_o)
);

// ==== bcMinerTb.sv ====
`timescale 1ns/1ps

module bcMinerTb import minerPkg::*; ();

	localparam int WAIT_LIMIT = 2000; // Cycles per wait

	logic        clk;
	logic        arstN;
	logic        wrReq;
	logic [2:0]  wrAddr;
	logic [31:0] wrData;
	logic        wrAck;
	logic        resReq;
	logic        resAck;
	logic        resSuccess;
	logic [31:0] resNonce;

	logic [31:0] hdr [HEADER_WORDS]; // Host copy of the block
	logic [31:0] tgt;
	logic [31:0] lcgState;
	logic        resClosed;
	int          errCnt;
	int          toCnt;

	bcMiner dut (
		.clk          (clk),
		.arstN_i      (arstN),
		.wrReq_i      (wrReq),
		.wrAddr_i     (wrAddr),
		.wrData_i     (wrData),
		.wrAck_o      (wrAck),
		.resReq_o     (resReq),
		.resAck_i     (resAck),
		.resSuccess_o (resSuccess),
		.resNonce_o   (resNonce)
	);

	always #10 clk = ~clk;

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] modelHash(input logic [31:0] nonce);
		logic [31:0] state;
		state = nonce;
		for (int r = 0; r < HASH_ROUNDS; r++) begin
			state = state ^ hdr[r];
			state = (state << 5) | (state >> 27);
			state = state + ROUND_CONST[r];
		end
		return state;
	endfunction

	// First hit in time order, ties to the lower core
	function automatic nonceWord_t expectedResult(output logic found);
		nonceWord_t n;
		int         c;
		found = 1'b0;
		n.raw = '0;
		for (int s = 0; s < SEARCH_LIMIT + NUM_CORES - 1; s++) begin
			for (int i = 0; i < NUM_CORES; i++) begin
				c = s - i;
				if (!found && c >= 0 && c < SEARCH_LIMIT &&
						modelHash(32'(c * NUM_CORES + i)) < tgt) begin
					found = 1'b1;
					n.raw = 32'(c * NUM_CORES + i);
				end
			end
		end
		return n;
	endfunction

	// ------------------------------
	// Checks and bus tasks
	// ------------------------------
	task automatic checkNonce(input string name, input nonceWord_t got, input nonceWord_t exp);
		if (got.raw !== exp.raw) begin
			$display("Fail %s: got %h expected %h", name, got.raw, exp.raw);
			errCnt++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errCnt++;
		end
	endtask

	task automatic writeWord(input logic [2:0] addr, input logic [31:0] data);
		int n;
		@(negedge clk);
		wrReq  = 1'b1;
		wrAddr = addr;
		wrData = data;
		n = 0;
		while (wrAck !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (wrAck !== 1'b1) begin
			$display("Timeout: no write ack for address %0d", addr);
			toCnt++;
		end
		wrReq = 1'b0;
		n = 0;
		while (wrAck !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (wrAck !== 1'b0) begin
			$display("Timeout: write ack never dropped after the request fell");
			toCnt++;
		end
		if (addr == ADDR_TARGET) tgt = data;
		else hdr[addr[1:0]] = data;
	endtask

	task automatic readResult(input int ackDelay);
		logic       expFound;
		nonceWord_t expNonce;
		int         n;
		expNonce = expectedResult(expFound);
		n = 0;
		while (resReq !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (resReq !== 1'b1) begin
			$display("Timeout: the miner never offered a result");
			toCnt++;
		end else begin
			checkBit("resSuccess_o", resSuccess, expFound);
			checkNonce("resNonce_o", resNonce, expNonce);
			repeat (ackDelay) begin
				@(negedge clk);
				checkBit("resReq_o", resReq, 1'b1);
				checkBit("resSuccess_o", resSuccess, expFound);
				checkNonce("resNonce_o", resNonce, expNonce);
			end
			resAck = 1'b1;
			n = 0;
			while (resReq !== 1'b0 && n < WAIT_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (resReq !== 1'b0) begin
				$display("Timeout: result request stayed high after the ack");
				toCnt++;
			end
			resAck = 1'b0;
		end
	endtask

	task automatic writeHeader();
		for (int a = 0; a < HEADER_WORDS; a++) begin
			writeWord(3'(a), nextRand());
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic testIdle();
		checkBit("wrAck_o", wrAck, 1'b0);
		checkBit("resReq_o", resReq, 1'b0);
		repeat (5) begin
			@(negedge clk);
			checkBit("wrAck_o", wrAck, 1'b0);
			checkBit("resReq_o", resReq, 1'b0);
		end
	endtask

	task automatic testMaxTarget();
		writeHeader();
		writeWord(ADDR_TARGET, 32'hffff_ffff);
		readResult(0);
	endtask

	task automatic testRandomJobs();
		repeat (4) begin
			writeHeader();
			writeWord(ADDR_TARGET, nextRand() >> 7); // Roughly one hit per few hundred
			readResult(0);
		end
	endtask

	task automatic testZeroTarget();
		writeHeader();
		writeWord(ADDR_TARGET, 32'h0);
		readResult(0);
	endtask

	task automatic testHeldResult();
		writeHeader();
		writeWord(ADDR_TARGET, 32'h0800_0000);
		resClosed = 1'b0;
		fork
			begin
				readResult(30);
				resClosed = 1'b1;
			end
			begin
				writeWord(3'd0, nextRand()); // Stalls behind the open result
				if (resClosed !== 1'b1) begin
					$display("Header write was acked while the result was still open");
					errCnt++;
				end
			end
		join
		for (int a = 1; a < HEADER_WORDS; a++) begin
			writeWord(3'(a), nextRand());
		end
		writeWord(ADDR_TARGET, 32'h0800_0000);
		readResult(0);
	endtask

	initial begin
		clk      = 1'b0;
		arstN    = 1'b0;
		wrReq    = 1'b0;
		wrAddr   = '0;
		wrData   = '0;
		resAck   = 1'b0;
		tgt      = '0;
		lcgState = 32'h3fe0_4933;
		errCnt   = 0;
		toCnt    = 0;
		for (int a = 0; a < HEADER_WORDS; a++) hdr[a] = '0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;

		testIdle();
		testMaxTarget();
		testRandomJobs();
		testZeroTarget();
		testHeldResult();

		$display("Failed checks: %0d, timeouts: %0d", errCnt, toCnt);
		if (errCnt == 0 && toCnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== blockStore.sv ====
`timescale 1ns/1ps

module blockStore import minerPkg::*; (
	input  logic                          clk,
	input  logic                          arstN_i,
	input  logic                          wrReq_i,
	input  logic [2:0]                    wrAddr_i,
	input  logic [31:0]                   wrData_i,
	output logic                          wrAck_o,
	input  logic                          searchDone_i,
	output logic                          bcValid_o,
	output logic                          bcNewBlock_o,
	output logic [HEADER_WORDS-1:0][31:0] bcHeader_o,
	output logic [31:0]                   bcTarget_o
);

	logic                          ackQ;
	logic                          tgtAckQ;
	logic                          newBlockQ;
	logic                          bcValidQ;
	logic                          busy;
	logic                          accept;
	logic [HEADER_WORDS-1:0][31:0] headerQ;
	logic [31:0]                   targetQ;

	// Writes wait while a job or its result is open
	assign busy   = bcValidQ | searchDone_i;
	assign accept = wrReq_i & ~ackQ & ~busy;

	// ------------------------------
	// Write handshake and job start
	// ------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			ackQ      <= 1'b0;
			tgtAckQ   <= 1'b0;
			newBlockQ <= 1'b0;
			bcValidQ  <= 1'b0;
		end else begin
			if (accept) begin
				ackQ <= 1'b1;
			end else if (ackQ && !wrReq_i) begin
				ackQ <= 1'b0;
			end
			tgtAckQ   <= accept & (wrAddr_i == ADDR_TARGET);
			newBlockQ <= tgtAckQ;  // Pulse one cycle after the ack
			if (tgtAckQ) begin
				bcValidQ <= 1'b1;
			end else if (searchDone_i) begin
				bcValidQ <= 1'b0;
			end
		end
	end

	// ------------------------------
	// Header and target registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			if (wrAddr_i < 3'(HEADER_WORDS)) begin
				headerQ[wrAddr_i[1:0]] <= wrData_i;
			end else if (wrAddr_i == ADDR_TARGET) begin
				targetQ <= wrData_i;
			end
		end
	end

	assign wrAck_o      = ackQ;
	assign bcValid_o    = bcValidQ;
	assign bcNewBlock_o = newBlockQ;
	assign bcHeader_o   = headerQ;
	assign bcTarget_o   = targetQ;

endmodule

// ==== hashCore.sv ====
`timescale 1ns/1ps

module hashCore import minerPkg::*; (
	input  logic                          clk,
	input  logic                          arstN_i,
	input  logic                          valid_i,
	input  logic                          last_i,
	input  nonceWord_t                    nonce_i,
	input  logic [HEADER_WORDS-1:0][31:0] header_i,
	output logic                          valid_o,
	output logic                          last_o,
	output nonceWord_t                    nonce_o,
	output logic [31:0]                   hash_o
);

	logic [HASH_ROUNDS-1:0]        validQ;
	logic [HASH_ROUNDS-1:0]        lastQ;
	logic [HASH_ROUNDS-1:0][31:0]  stateQ;
	nonceWord_t [HASH_ROUNDS-1:0]  nonceQ;

	// xor word, rotate left 5, add constant
	function automatic logic [31:0] hashRound(
		input logic [31:0] state,
		input logic [31:0] word,
		input logic [31:0] rc
	);
		logic [31:0] mixed;
		mixed = state ^ word;
		return {mixed[26:0], mixed[31:27]} + rc;
	endfunction

	// ------------------------------
	// Stage control
	// ------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			validQ <= '0;
			lastQ  <= '0;
		end else begin
			validQ <= {validQ[HASH_ROUNDS-2:0], valid_i};
			lastQ  <= {lastQ[HASH_ROUNDS-2:0], last_i};
		end
	end

	// ------------------------------
	// Round datapath
	// ------------------------------
	always_ff @(posedge clk) begin
		stateQ[0] <= hashRound(nonce_i.raw, header_i[0], ROUND_CONST[0]);
		nonceQ[0] <= nonce_i;
		for (int r = 1; r < HASH_ROUNDS; r++) begin
			stateQ[r] <= hashRound(stateQ[r-1], header_i[r], ROUND_CONST[r]);
			nonceQ[r] <= nonceQ[r-1]; // Nonce rides with its state
		end
	end

	assign valid_o = validQ[HASH_ROUNDS-1];
	assign last_o  = lastQ[HASH_ROUNDS-1];
	assign nonce_o = nonceQ[HASH_ROUNDS-1];
	assign hash_o  = stateQ[HASH_ROUNDS-1];

endmodule

// ==== latticeBlock.sv ====
`timescale 1ns/1ps

module latticeBlock import minerPkg::*; #(
	parameter int INDEX = 0
) (
	input  logic                          clk,
	input  logic                          arstN_i,
	input  logic                          bcValid_i,
	input  logic                          bcNewBlock_i,
	input  logic [HEADER_WORDS-1:0][31:0] bcHeader_i,
	input  logic [31:0]                   bcTarget_i,
	output logic                          bcValid_o,
	output logic                          bcNewBlock_o,
	output logic [HEADER_WORDS-1:0][31:0] bcHeader_o,
	output logic [31:0]                   bcTarget_o,
	output logic                          hit_o,
	output logic [CNT_BITS-1:0]           hitCnt_o,
	output logic                          exhausted_o
);

	logic                bcValidQ;
	logic                bcNewBlockQ;
	logic [CNT_BITS-1:0] cntQ;
	logic                runQ;
	logic [CNT_BITS-1:0] curCnt;
	logic                feedValid;
	logic                feedLast;
	nonceWord_t          feedNonce;
	logic                coreValid;
	logic                coreLast;
	nonceWord_t          coreNonce;
	logic [31:0]         coreHash;

	// ------------------------------
	// Broadcast forward stage
	// ------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			bcValidQ    <= 1'b0;
			bcNewBlockQ <= 1'b0;
		end else begin
			bcValidQ    <= bcValid_i;
			bcNewBlockQ <= bcNewBlock_i;
		end
	end

	always_ff @(posedge clk) begin
		bcHeader_o <= bcHeader_i;
		bcTarget_o <= bcTarget_i;
	end

	assign bcValid_o    = bcValidQ;
	assign bcNewBlock_o = bcNewBlockQ;

	// ------------------------------
	// Nonce counter
	// ------------------------------
	assign curCnt    = bcNewBlock_i ? '0 : cntQ; // Counter 0 goes in with the pulse
	assign feedValid = bcNewBlock_i | (runQ & bcValid_i);
	assign feedLast  = feedValid & (curCnt == CNT_BITS'(SEARCH_LIMIT - 1));

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			cntQ <= '0;
			runQ <= 1'b0;
		end else if (bcNewBlock_i) begin
			cntQ <= CNT_BITS'(1);
			runQ <= 1'b1;
		end else if (runQ) begin
			if (!bcValid_i || feedLast) begin
				runQ <= 1'b0;  // Search stopped or space done
			end else begin
				cntQ <= cntQ + 1'b1;
			end
		end
	end

	always_comb begin
		feedNonce.fields.cnt  = curCnt;
		feedNonce.fields.core = CORE_BITS'(INDEX);
	end

	hashCore hashCoreInst (
		.clk,
		.arstN_i,
		.valid_i  (feedValid),
		.last_i   (feedLast),
		.nonce_i  (feedNonce),
		.header_i (bcHeader_i),
		.valid_o  (coreValid),
		.last_o   (coreLast),
		.nonce_o  (coreNonce),
		.hash_o   (coreHash)
	);

	// Results that land after the broadcast ends are stale
	assign hit_o       = coreValid & bcValid_i & (coreHash < bcTarget_i);
	assign hitCnt_o    = coreNonce.fields.cnt;
	assign exhausted_o = coreValid & coreLast & bcValid_i;

endmodule

// ==== minerPkg.sv ====
package minerPkg;

	// ------------------------------
	// Array geometry
	// ------------------------------
	localparam int NUM_CORES    = 4;
	localparam int CORE_BITS    = 2;   // Low nonce bits pick the core
	localparam int CNT_BITS     = 30;
	localparam int SEARCH_LIMIT = 256; // Nonces per core per job

	// ------------------------------
	// Hash and host map
	// ------------------------------
	localparam int HASH_ROUNDS  = 4;   // One pipeline stage per round
	localparam int HEADER_WORDS = 4;
	localparam logic [2:0] ADDR_TARGET = 3'd4;

	// Index 0 is the first round
	localparam logic [HASH_ROUNDS-1:0][31:0] ROUND_CONST = {
		32'he9b5_dba5,
		32'hb5c0_fbcf,
		32'h7137_4491,
		32'h428a_2f98
	};

	// Cores build the nonce from fields, the host reads it raw
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [CNT_BITS-1:0]  cnt;
			logic [CORE_BITS-1:0] core;
		} fields;
	} nonceWord_t;

endpackage

// ==== nonceDecoder.sv ====
`timescale 1ns/1ps

module nonceDecoder import minerPkg::*; (
	input  logic                               clk,
	input  logic                               arstN_i,
	input  logic [NUM_CORES-1:0]               hit_i,
	input  logic [NUM_CORES-1:0][CNT_BITS-1:0] hitCnt_i,
	input  logic [NUM_CORES-1:0]               exhausted_i,
	output logic                               searchDone_o,
	output logic                               resReq_o,
	input  logic                               resAck_i,
	output logic                               resSuccess_o,
	output logic [31:0]                        resNonce_o
);

	logic                 searchDoneQ;
	logic                 resReqQ;
	logic                 ackSeenQ;
	logic [2:0]           drainCntQ;
	logic [NUM_CORES-1:0] exhSeenQ;
	logic                 resSuccessQ;
	nonceWord_t           resWordQ;
	logic                 hitAny;
	logic [CORE_BITS-1:0] hitSel;
	logic                 armed;
	logic                 exhAll;
	logic                 decide;

	// Lowest core wins within a cycle
	always_comb begin
		hitAny = |hit_i;
		hitSel = '0;
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (hit_i[i]) hitSel = CORE_BITS'(i);
		end
	end

	// Drain lets stale core results run out after a job
	assign armed  = ~searchDoneQ & (drainCntQ == '0);
	assign exhAll = &(exhSeenQ | exhausted_i);
	assign decide = armed & (hitAny | exhAll);

	// ------------------------------
	// Decision and result handshake
	// ------------------------------
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			searchDoneQ <= 1'b0;
			resReqQ     <= 1'b0;
			ackSeenQ    <= 1'b0;
			drainCntQ   <= '0;
			exhSeenQ    <= '0;
		end else begin
			if (decide) begin
				searchDoneQ <= 1'b1;
				resReqQ     <= 1'b1;
				exhSeenQ    <= '0;
			end else if (armed) begin
				exhSeenQ <= exhSeenQ | exhausted_i;
			end
			if (resReqQ && resAck_i) begin
				resReqQ  <= 1'b0;
				ackSeenQ <= 1'b1;
			end
			if (ackSeenQ && !resAck_i) begin
				ackSeenQ    <= 1'b0;
				searchDoneQ <= 1'b0; // Handshake closed
				drainCntQ   <= 3'(NUM_CORES + 1);
			end else if (drainCntQ != '0) begin
				drainCntQ <= drainCntQ - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (decide) begin
			resSuccessQ <= hitAny;
			if (hitAny) begin
				resWordQ.fields.cnt  <= hitCnt_i[hitSel];
				resWordQ.fields.core <= hitSel;
			end else begin
				resWordQ.raw <= '0;
			end
		end
	end

	assign searchDone_o = searchDoneQ;
	assign resReq_o     = resReqQ;
	assign resSuccess_o = resSuccessQ;
	assign resNonce_o   = resWordQ.raw;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the miner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bcMinerTb -f bcMiner.f

./obj_dir/VbcMinerTb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
